/* compile.f */
hw/hangman_pkg.sv
hw/guess_if.sv
hw/word_setter.sv
hw/guess_judge.sv
hw/host_disp.sv
hw/hangman_host_top.sv
tests/hangman_checker.sv
tests/hangman_tb.sv

/* tests/hangman_tb.sv */
// hangman host testbench
// directed setup, reveal, miss, win and loss rounds checked on both display rows

`timescale 1ns/100ps

module hangman_tb;

    localparam int MAX_CYCLES = 2000; // about 30 key presses of 4 cycles, wide margin
    localparam int KEY_SET    = 0;
    localparam int KEY_START  = 1;
    localparam int KEY_GUESS  = 2;
    localparam int KEY_NEW    = 3;

    logic         clk = 1'b0;
    logic         nRst;
    logic [7:0]   key_letter;
    logic         set_key;
    logic         start_key;
    logic         guess_key;
    logic         new_game;
    logic [127:0] top;
    logic [127:0] bottom;
    logic [39:0]  secret;   // character 0 in top byte
    logic [39:0]  exp_word; // letters as entered so far
    logic [39:0]  exp_rev;
    logic [47:0]  exp_miss; // newest miss leftmost
    int           misses;
    int           checks;
    int           errors;
    int           cycles;
    int           rnd;

    hangman_host_top i_dut (
        .clk        (clk),
        .nRst       (nRst),
        .key_letter (key_letter),
        .set_key    (set_key),
        .start_key  (start_key),
        .guess_key  (guess_key),
        .new_game   (new_game),
        .top        (top),
        .bottom     (bottom)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // text placed from character lead on, rest of the row spaces
    function automatic logic [127:0] make_row(input int lead, input logic [47:0] text,
                                              input int len);
        logic [127:0] row;
        row = {16{8'h20}};
        for (int i = 0; i < len; i++) begin
            row[(15-lead-i)*8 +: 8] = text[(len-1-i)*8 +: 8];
        end
        return row;
    endfunction

    function automatic logic in_word(input logic [7:0] letter);
        logic found;
        found = 1'b0;
        for (int p = 0; p < 5; p++) begin
            found = found | (secret[p*8 +: 8] == letter);
        end
        return found;
    endfunction

    function automatic logic [7:0] pick_miss();
        logic [7:0] l;
        do begin
            l = 8'h41 + 8'($urandom % 26);
        end while (in_word(l));
        return l;
    endfunction

    task automatic check_rows(input logic [127:0] exp_top, input logic [127:0] exp_bot);
        checks++;
        if (top !== exp_top) begin
            errors++;
            $display("** Error: top = %h, expected %h", top, exp_top);
        end
        if (bottom !== exp_bot) begin
            errors++;
            $display("** Error: bottom = %h, expected %h", bottom, exp_bot);
        end
    endtask

    // one-cycle key pulse, then two cycles for the rows to follow
    task automatic press(input int which, input logic [7:0] letter);
        @(posedge clk);
        key_letter <= letter;
        set_key    <= (which == KEY_SET);
        start_key  <= (which == KEY_START);
        guess_key  <= (which == KEY_GUESS);
        new_game   <= (which == KEY_NEW);
        @(posedge clk);
        {set_key, start_key, guess_key, new_game} <= 4'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check_play();
        if (exp_rev == secret) begin
            check_rows(make_row(7, "Win", 3), make_row(6, secret, 5));
        end else if (misses >= 6) begin
            check_rows(make_row(6, "Lose", 4), make_row(6, secret, 5));
        end else begin
            check_rows(make_row(6, exp_rev, 5), make_row(5, exp_miss, 6));
        end
    endtask

    task automatic new_round();
        exp_word = {5{8'h20}};
        exp_rev  = {5{8'h5F}};
        exp_miss = {6{8'h5F}};
        misses   = 0;
        press(KEY_NEW, 8'h00);
        check_rows({16{8'h20}}, {16{8'h20}});
    endtask

    // an early start after three letters must leave the setup rows alone
    task automatic enter_word(input logic [39:0] word, input logic early_start);
        for (int i = 4; i >= 0; i--) begin
            exp_word = {exp_word[31:0], word[i*8 +: 8]};
            press(KEY_SET, word[i*8 +: 8]);
            check_rows(make_row(7, word[i*8 +: 8], 1), make_row(6, exp_word, 5));
            if (early_start && i == 2) begin
                press(KEY_START, 8'h00);
                check_rows(make_row(7, word[i*8 +: 8], 1), make_row(6, exp_word, 5));
            end
        end
        secret = word;
        press(KEY_START, 8'h00);
        check_play();
    endtask

    task automatic guess(input logic [7:0] letter);
        if (exp_rev != secret && misses < 6) begin
            for (int p = 0; p < 5; p++) begin
                if (secret[p*8 +: 8] == letter) begin
                    exp_rev[p*8 +: 8] = letter;
                end
            end
            if (!in_word(letter)) begin
                exp_miss = {letter, exp_miss[47:8]};
                misses++;
            end
        end
        press(KEY_GUESS, letter);
        check_play();
    endtask

    // rows must stay zero on idle cycles until the first new_game
    task automatic test_reset_setup();
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_rows('0, '0);
        new_round();
        enter_word("APPLE", 1'b1);
    endtask

    task automatic test_reveal();
        guess("P"); // both P positions at once
        guess("P");
    endtask

    task automatic test_misses();
        repeat (3) guess(pick_miss());
    endtask

    task automatic test_win();
        guess("A");
        guess("L");
        guess("E");
        guess(pick_miss()); // round over, rows hold
    endtask

    task automatic test_loss();
        new_round();
        enter_word("GHOST", 1'b0);
        repeat (6) guess(pick_miss());
        guess("G");
    endtask

    initial begin
        rnd        = $urandom(32'had0dd2e7);
        nRst       = 1'b0;
        key_letter = 8'h00;
        set_key    = 1'b0;
        start_key  = 1'b0;
        guess_key  = 1'b0;
        new_game   = 1'b0;
        repeat (3) @(posedge clk);
        nRst <= 1'b1;
        @(negedge clk);
        test_reset_setup();
        test_reveal();
        test_misses();
        test_win();
        test_loss();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* tests/hangman_checker.sv */
// protocol checker for the hangman host
// bound to the top level, watches the start pulse and the guess channel

`timescale 1ns/100ps

module hangman_checker (
    input logic       clk,
    input logic       nRst,
    input logic       toggle_state,
    input logic       judged,
    input logic       won,
    input logic       lost,
    input logic       mistake,
    input logic [4:0] index_correct
);

    toggle_one_cycle: assert property (@(posedge clk) disable iff (!nRst)
        toggle_state |=> !toggle_state)
        else $error("toggle_state high for more than one cycle");

    judged_one_cycle: assert property (@(posedge clk) disable iff (!nRst)
        judged |=> !judged)
        else $error("judged high for more than one cycle");

    won_lost_exclusive: assert property (@(posedge clk) disable iff (!nRst)
        !(won && lost))
        else $error("won and lost high together");

    miss_reveals_nothing: assert property (@(posedge clk) disable iff (!nRst)
        mistake |-> (index_correct == '0))
        else $error("index_correct set while mistake is high");

endmodule

bind hangman_host_top hangman_checker i_checker (
    .clk           (clk),
    .nRst          (nRst),
    .toggle_state  (toggle_state),
    .judged        (gi.judged),
    .won           (gi.won),
    .lost          (gi.lost),
    .mistake       (gi.mistake),
    .index_correct (gi.index_correct)
);

/* hw/hangman_host_top.sv */
// hangman host top level
// word setter, guess judge and display composer joined by one guess channel

`timescale 1ns/100ps

module hangman_host_top #(
    parameter int MAX_MISSES = 6 // legal range 1 to 6
) (
    input  logic                           clk,
    input  logic                           nRst,
    input  logic [hangman_pkg::CHAR_W-1:0] key_letter,
    input  logic                           set_key,
    input  logic                           start_key,
    input  logic                           guess_key,
    input  logic                           new_game,
    output hangman_pkg::row_t              top,
    output hangman_pkg::row_t              bottom
);

    hangman_pkg::word_t             temp_word;
    logic [hangman_pkg::CHAR_W-1:0] set_letter;
    logic                           toggle_state;

    guess_if gi ();

    word_setter i_setter (
        .clk          (clk),
        .nRst         (nRst),
        .key_letter   (key_letter),
        .set_key      (set_key),
        .start_key    (start_key),
        .new_game     (new_game),
        .temp_word    (temp_word),
        .set_letter   (set_letter),
        .toggle_state (toggle_state)
    );

    guess_judge #(
        .MAX_MISSES (MAX_MISSES)
    ) i_judge (
        .clk          (clk),
        .nRst         (nRst),
        .key_letter   (key_letter),
        .guess_key    (guess_key),
        .new_game     (new_game),
        .toggle_state (toggle_state),
        .temp_word    (temp_word),
        .gi           (gi.judge)
    );

    host_disp i_disp (
        .clk          (clk),
        .nRst         (nRst),
        .set_letter   (set_letter),
        .temp_word    (temp_word),
        .toggle_state (toggle_state),
        .new_game     (new_game),
        .gi           (gi.disp),
        .top          (top),
        .bottom       (bottom)
    );

endmodule

/* hw/host_disp.sv */
// host display composer
// setup/play state machine that builds the two 16-character ASCII rows

`timescale 1ns/100ps

module host_disp (
    input  logic                           clk,
    input  logic                           nRst,
    input  logic [hangman_pkg::CHAR_W-1:0] set_letter,
    input  hangman_pkg::word_t             temp_word,
    input  logic                           toggle_state,
    input  logic                           new_game,
    guess_if.disp                          gi,
    output hangman_pkg::row_t              top,
    output hangman_pkg::row_t              bottom
);

    localparam int                CW     = hangman_pkg::CHAR_W;
    localparam int                MISS_W = hangman_pkg::GUESS_SLOTS * CW;
    localparam logic [CW-1:0]     SP     = hangman_pkg::CH_SPACE;
    localparam logic [CW-1:0]     BL     = hangman_pkg::CH_BLANK;

    typedef enum logic {
        SET     = 1'b0,
        COMPARE = 1'b1
    } disp_state_t;

    disp_state_t        state;
    disp_state_t        next_state;
    hangman_pkg::word_t rev_word;       // revealed word, underscores when hidden
    hangman_pkg::word_t next_rev_word;
    logic [MISS_W-1:0]  miss_list;      // newest miss leftmost
    logic [MISS_W-1:0]  next_miss_list;
    hangman_pkg::row_t  next_top;
    hangman_pkg::row_t  next_bottom;
    hangman_pkg::row_t  setup_bottom;
    logic               active;         // rows stay dark until the first new_game
    logic               next_active;

    // shared by setup and both end screens
    assign setup_bottom = {{6{SP}}, temp_word, {5{SP}}};

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state     <= SET;
            rev_word  <= {hangman_pkg::WORD_LEN{BL}};
            miss_list <= {hangman_pkg::GUESS_SLOTS{BL}};
            top       <= '0;
            bottom    <= '0;
            active    <= 1'b0;
        end else begin
            state     <= next_state;
            rev_word  <= next_rev_word;
            miss_list <= next_miss_list;
            top       <= next_top;
            bottom    <= next_bottom;
            active    <= next_active;
        end
    end

    always_comb begin
        next_state     = state;
        next_rev_word  = rev_word;
        next_miss_list = miss_list;
        next_top       = top;
        next_bottom    = bottom;
        next_active    = active;

        if (new_game) begin
            next_state     = SET;
            next_rev_word  = {hangman_pkg::WORD_LEN{BL}};
            next_miss_list = {hangman_pkg::GUESS_SLOTS{BL}};
            next_top       = {hangman_pkg::ROW_CHARS{SP}};
            next_bottom    = {hangman_pkg::ROW_CHARS{SP}};
            next_active    = 1'b1;
        end else begin
            case (state)
                SET: begin
                    if (toggle_state) begin
                        next_state = COMPARE;
                    end
                    if (active) begin
                        next_top    = {{7{SP}}, set_letter, {8{SP}}};
                        next_bottom = setup_bottom;
                    end
                end
                COMPARE: begin
                    if (gi.judged) begin
                        // judge flags only still-hidden positions
                        for (int i = 0; i < hangman_pkg::WORD_LEN; i++) begin
                            if (gi.index_correct[i]) begin
                                next_rev_word[i*CW +: CW] = gi.letter;
                            end
                        end
                        if (gi.mistake) begin
                            next_miss_list = {gi.letter, miss_list[MISS_W-1:CW]}; // oldest drops
                        end
                    end
                    if (active) begin
                        if (gi.won) begin
                            next_top    = {{7{SP}}, hangman_pkg::WIN_TEXT, {6{SP}}};
                            next_bottom = setup_bottom;
                        end else if (gi.lost) begin
                            next_top    = {{6{SP}}, hangman_pkg::LOSE_TEXT, {6{SP}}};
                            next_bottom = setup_bottom;
                        end else begin
                            next_top    = {{6{SP}}, rev_word, {5{SP}}};
                            next_bottom = {{5{SP}}, miss_list, {5{SP}}};
                        end
                    end
                end
                default: begin
                    next_state = SET;
                end
            endcase
        end
    end

endmodule

/* hw/guess_judge.sv */
// guess judge for the hangman host
// compares each guess with the secret word, tracks reveals and misses,
// and decides win or loss

`timescale 1ns/100ps

module guess_judge #(
    parameter int MAX_MISSES = 6
) (
    input  logic                           clk,
    input  logic                           nRst,
    input  logic [hangman_pkg::CHAR_W-1:0] key_letter,
    input  logic                           guess_key,
    input  logic                           new_game,
    input  logic                           toggle_state,
    input  hangman_pkg::word_t             temp_word,
    guess_if.judge                         gi
);

    localparam int         CW         = hangman_pkg::CHAR_W;
    localparam int         WL         = hangman_pkg::WORD_LEN;
    localparam logic [2:0] MISS_LIMIT = 3'(MAX_MISSES);

    logic          playing;   // between start pulse and new_game
    logic [WL-1:0] revealed;  // bit i covers word character at bits i*CW
    logic [WL-1:0] match;
    logic [WL-1:0] fresh;     // matches still hidden
    logic [2:0]    miss_cnt;
    logic [2:0]    miss_next;
    logic          miss;
    logic          accept;

    always_comb begin
        for (int i = 0; i < WL; i++) begin
            match[i] = (temp_word[i*CW +: CW] == key_letter);
        end
    end

    assign fresh     = match & ~revealed;
    assign miss      = ~|match;            // a revealed letter is still no miss
    assign miss_next = miss_cnt + 3'd1;
    assign accept    = guess_key && playing && !gi.won && !gi.lost;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            playing          <= 1'b0;
            revealed         <= '0;
            miss_cnt         <= '0;
            gi.judged        <= 1'b0;
            gi.index_correct <= '0;
            gi.mistake       <= 1'b0;
            gi.won           <= 1'b0;
            gi.lost          <= 1'b0;
        end else if (new_game) begin
            playing          <= 1'b0;
            revealed         <= '0;
            miss_cnt         <= '0;
            gi.judged        <= 1'b0;
            gi.index_correct <= '0;
            gi.mistake       <= 1'b0;
            gi.won           <= 1'b0;
            gi.lost          <= 1'b0;
        end else begin
            gi.judged <= accept;
            if (toggle_state) begin
                playing <= 1'b1;
            end
            if (accept) begin
                gi.index_correct <= fresh;
                gi.mistake       <= miss;
                revealed         <= revealed | match;
                if (miss) begin
                    miss_cnt <= miss_next; // repeats of a wrong letter count again
                end
                gi.won  <= &(revealed | match);
                gi.lost <= miss && (miss_next == MISS_LIMIT);
            end
        end
    end

    // letter captured with each accepted guess
    always_ff @(posedge clk) begin
        if (accept) begin
            gi.letter <= key_letter;
        end
    end

endmodule

/* hw/word_setter.sv */
// secret word entry for the host
// shifts letters into a five-character word and issues one start pulse

`timescale 1ns/100ps

module word_setter (
    input  logic                           clk,
    input  logic                           nRst,
    input  logic [hangman_pkg::CHAR_W-1:0] key_letter,
    input  logic                           set_key,
    input  logic                           start_key,
    input  logic                           new_game,
    output hangman_pkg::word_t             temp_word,
    output logic [hangman_pkg::CHAR_W-1:0] set_letter,
    output logic                           toggle_state
);

    localparam int          WORD_W = hangman_pkg::WORD_LEN * hangman_pkg::CHAR_W;
    localparam logic [2:0]  FULL   = 3'(hangman_pkg::WORD_LEN);

    logic [2:0] count;   // letters entered, saturates at FULL
    logic       started; // start pulse already issued

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            temp_word    <= {hangman_pkg::WORD_LEN{hangman_pkg::CH_SPACE}};
            set_letter   <= hangman_pkg::CH_SPACE;
            count        <= '0;
            started      <= 1'b0;
            toggle_state <= 1'b0;
        end else begin
            toggle_state <= 1'b0; // single cycle pulse
            if (new_game) begin
                // spaces keep the setup rows blank until the next letter
                temp_word  <= {hangman_pkg::WORD_LEN{hangman_pkg::CH_SPACE}};
                set_letter <= hangman_pkg::CH_SPACE;
                count      <= '0;
                started    <= 1'b0;
            end else if (!started) begin
                if (set_key) begin
                    temp_word  <= {temp_word[WORD_W-hangman_pkg::CHAR_W-1:0], key_letter};
                    set_letter <= key_letter;
                    if (count != FULL) begin
                        count <= count + 3'd1;
                    end
                end
                if (start_key && count == FULL) begin // ignored until word complete
                    toggle_state <= 1'b1;
                    started      <= 1'b1;
                end
            end
        end
    end

endmodule

/* hw/guess_if.sv */
// judged guess channel between the guess judge and the host display
// letter, index_correct and mistake are valid only while judged is high

`timescale 1ns/100ps

interface guess_if;

    logic [hangman_pkg::CHAR_W-1:0]   letter;        // the judged letter
    logic [hangman_pkg::WORD_LEN-1:0] index_correct; // newly revealed positions
    logic                             mistake;       // letter not in the word
    logic                             judged;        // one-cycle strobe
    logic                             won;           // held until new_game
    logic                             lost;          // held until new_game

    modport judge (
        output letter, index_correct, mistake, judged, won, lost
    );

    modport disp (
        input letter, index_correct, mistake, judged, won, lost
    );

endinterface

/* hw/hangman_pkg.sv */
// hangman host shared definitions
// game sizes, ASCII constants and the word and row types

package hangman_pkg;

    // game sizes
    localparam int WORD_LEN    = 5;  // letters in the secret word
    localparam int GUESS_SLOTS = 6;  // miss slots on the bottom row
    localparam int CHAR_W      = 8;  // one ASCII character
    localparam int ROW_CHARS   = 16; // characters per display row

    // ASCII characters used by the display
    localparam logic [CHAR_W-1:0] CH_SPACE = 8'h20;
    localparam logic [CHAR_W-1:0] CH_BLANK = 8'h5F; // underscore marks a hidden slot

    // end-of-round banners, first character in the top byte
    localparam logic [3*CHAR_W-1:0] WIN_TEXT  = {8'h57, 8'h69, 8'h6E};        // "Win"
    localparam logic [4*CHAR_W-1:0] LOSE_TEXT = {8'h4C, 8'h6F, 8'h73, 8'h65}; // "Lose"

    // character 0 sits in the top byte of both types
    typedef logic [WORD_LEN*CHAR_W-1:0]  word_t;
    typedef logic [ROW_CHARS*CHAR_W-1:0] row_t;

endpackage
